// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // bus widths.
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;  // all zero means read.

  // address map as base and offset mask pairs.
  localparam logic [addr_width-1:0] tim_base_addr = 32'h0001_0000;
  localparam logic [addr_width-1:0] tim_mask_addr = 32'h0000_0FFF;
  localparam logic [addr_width-1:0] clint_base_addr = 32'h0200_0000;
  localparam logic [addr_width-1:0] clint_mask_addr = 32'h0000_FFFF;
  localparam logic [addr_width-1:0] uart_tx_base_addr = 32'h1000_0000;
  localparam logic [addr_width-1:0] uart_tx_mask_addr = 32'h0000_000F;

  localparam int tim_depth = 1024;  // words.

  // clint register offsets with the high words at +4.
  localparam logic [addr_width-1:0] clint_msip_offset = 32'h0000_0000;
  localparam logic [addr_width-1:0] clint_mtimecmp_offset = 32'h0000_4000;
  localparam logic [addr_width-1:0] clint_mtime_offset = 32'h0000_BFF8;
  localparam int clk_divider_rtc = 8;  // clocks per mtime tick.

  // uart transmitter.
  localparam int clk_divider_bit = 16;  // clocks per bit.
  localparam int uart_frame_bits = 10;  // start, 8 data, stop.
  localparam logic [addr_width-1:0] uart_data_offset = 32'h0000_0000;
  localparam logic [addr_width-1:0] uart_status_offset = 32'h0000_0004;

endpackage

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
`default_nettype none

module bus_decoder
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  mem_valid,
  input  logic [addr_width-1:0] mem_addr,
  output logic                  mem_ready,
  output logic [data_width-1:0] mem_rdata,
  output logic                  mem_error,
  output logic [addr_width-1:0] slave_addr,
  output logic                  tim_valid,
  input  logic                  tim_ready,
  input  logic [data_width-1:0] tim_rdata,
  output logic                  clint_valid,
  input  logic                  clint_ready,
  input  logic [data_width-1:0] clint_rdata,
  output logic                  uart_valid,
  input  logic                  uart_ready,
  input  logic [data_width-1:0] uart_rdata
);

  logic                  tim_hit;
  logic                  clint_hit;
  logic                  uart_hit;
  logic                  error_valid;
  logic                  error_ready;
  logic [addr_width-1:0] base_addr;

  // a window matches when the address with its offset bits cleared equals the base.
  always_comb begin
    tim_hit = (mem_addr & ~tim_mask_addr) == tim_base_addr;
    clint_hit = (mem_addr & ~clint_mask_addr) == clint_base_addr;
    uart_hit = (mem_addr & ~uart_tx_mask_addr) == uart_tx_base_addr;
  end

  always_comb begin
    base_addr = '0;
    if (tim_hit) begin
      base_addr = tim_base_addr;
    end
    if (clint_hit) begin
      base_addr = clint_base_addr;
    end
    if (uart_hit) begin
      base_addr = uart_tx_base_addr;
    end
  end

  assign slave_addr = mem_addr - base_addr;  // base-relative offset.

  assign tim_valid = mem_valid & tim_hit;
  assign clint_valid = mem_valid & clint_hit;
  assign uart_valid = mem_valid & uart_hit;
  assign error_valid = mem_valid & ~(tim_hit | clint_hit | uart_hit);

  // unmapped requests get an error one cycle later.
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= error_valid;
    end
  end

  // only the addressed slave can pulse ready, so ready picks the data.
  always_comb begin
    mem_rdata = '0;
    if (tim_ready) begin
      mem_rdata = tim_rdata;
    end
    if (clint_ready) begin
      mem_rdata = clint_rdata;
    end
    if (uart_ready) begin
      mem_rdata = uart_rdata;
    end
  end

  assign mem_ready = tim_ready | clint_ready | uart_ready | error_ready;
  assign mem_error = error_ready;  // error data stays zero.

endmodule

`default_nettype wire

// ==== rtl/tim.sv ====
`default_nettype none

module tim
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  valid,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic [strb_width-1:0] wstrb,
  output logic                  ready,
  output logic [data_width-1:0] rdata
);

  logic [data_width-1:0]        mem [tim_depth];
  logic [$clog2(tim_depth)-1:0] index;
  logic                         write;

  assign index = addr[$clog2(tim_depth)+1:2];  // word index.
  assign write = wstrb != '0;

  // byte lanes are written independently.
  always_ff @(posedge clock) begin
    if (valid && write) begin
      for (int i = 0; i < strb_width; i++) begin
        if (wstrb[i]) begin
          mem[index][8*i+:8] <= wdata[8*i+:8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (valid && !write) begin
      rdata <= mem[index];
    end else begin
      rdata <= '0;  // writes answer with zero.
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/clint.sv ====
`default_nettype none

module clint
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  valid,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic [strb_width-1:0] wstrb,
  output logic                  ready,
  output logic [data_width-1:0] rdata,
  output logic                  msip,
  output logic                  mtip
);

  logic [$clog2(clk_divider_rtc)-1:0] prescale;
  logic                               tick;
  logic [63:0]                        mtime;
  logic [63:0]                        mtimecmp;
  logic                               write;
  logic [data_width-1:0]              read_word;

  // merges a bus write into a register half under the byte strobes.
  function automatic logic [data_width-1:0] merge(input logic [data_width-1:0] old_word,
                                                  input logic [data_width-1:0] new_word,
                                                  input logic [strb_width-1:0] strb);
    logic [data_width-1:0] result;
    result = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        result[8*i+:8] = new_word[8*i+:8];
      end
    end
    return result;
  endfunction

  assign tick = prescale == $bits(prescale)'(clk_divider_rtc - 1);
  assign write = valid && (wstrb != '0);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      prescale <= '0;
      mtime <= '0;
      mtimecmp <= '1;  // keeps mtip low out of reset.
      msip <= 1'b0;
      mtip <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= valid;
      mtip <= mtime >= mtimecmp;
      prescale <= tick ? '0 : prescale + 1'b1;
      if (tick) begin
        mtime <= mtime + 64'd1;
      end
      // a bus write to mtime wins over the tick.
      if (write) begin
        case (addr)
          clint_msip_offset: begin
            if (wstrb[0]) msip <= wdata[0];
          end
          clint_mtimecmp_offset: mtimecmp[31:0] <= merge(mtimecmp[31:0], wdata, wstrb);
          clint_mtimecmp_offset + 32'd4: mtimecmp[63:32] <= merge(mtimecmp[63:32], wdata, wstrb);
          clint_mtime_offset: mtime[31:0] <= merge(mtime[31:0], wdata, wstrb);
          clint_mtime_offset + 32'd4: mtime[63:32] <= merge(mtime[63:32], wdata, wstrb);
          default: ;  // unknown offsets ignore writes.
        endcase
      end
    end
  end

  always_comb begin
    case (addr)
      clint_msip_offset: read_word = {{(data_width - 1) {1'b0}}, msip};
      clint_mtimecmp_offset: read_word = mtimecmp[31:0];
      clint_mtimecmp_offset + 32'd4: read_word = mtimecmp[63:32];
      clint_mtime_offset: read_word = mtime[31:0];
      clint_mtime_offset + 32'd4: read_word = mtime[63:32];
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    rdata <= (valid && !write) ? read_word : '0;
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`default_nettype none

module uart_tx
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  valid,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic [strb_width-1:0] wstrb,
  output logic                  ready,
  output logic [data_width-1:0] rdata,
  output logic                  tx
);

  logic [uart_frame_bits-1:0]         frame;
  logic [$clog2(clk_divider_bit)-1:0] baud_cnt;
  logic [$clog2(uart_frame_bits)-1:0] bit_cnt;
  logic                               busy;
  logic                               pending;
  logic [7:0]                         pend_data;
  logic                               data_wr;
  logic                               bit_end;
  logic                               frame_end;
  logic                               start;

  assign data_wr = valid && (wstrb != '0) && (addr == uart_data_offset);
  assign bit_end = baud_cnt == $bits(baud_cnt)'(clk_divider_bit - 1);
  assign frame_end = busy && bit_end && (bit_cnt == $bits(bit_cnt)'(uart_frame_bits - 1));
  // a new frame starts when idle or right after the stop bit.
  assign start = (pending || data_wr) && (!busy || frame_end);

  assign tx = frame[0];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      frame <= '1;  // line idles high.
      baud_cnt <= '0;
      bit_cnt <= '0;
      busy <= 1'b0;
      pending <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= start || (valid && !data_wr);  // held writes answer on start.
      if (start) begin
        frame <= {1'b1, pending ? pend_data : wdata[7:0], 1'b0};
        baud_cnt <= '0;
        bit_cnt <= '0;
        busy <= 1'b1;
        pending <= 1'b0;
      end else if (busy) begin
        if (bit_end) begin
          baud_cnt <= '0;
          frame <= {1'b1, frame[uart_frame_bits-1:1]};  // lsb first.
          if (frame_end) begin
            busy <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (data_wr) begin
          pending <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (data_wr) begin
      pend_data <= wdata[7:0];
    end
  end

  // status holds busy in bit 0.
  always_ff @(posedge clock) begin
    if (valid && (wstrb == '0) && (addr == uart_status_offset)) begin
      rdata <= {{(data_width - 1) {1'b0}}, busy};
    end else begin
      rdata <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/soc_bus.sv ====
`default_nettype none

module soc_bus
  import soc_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  mem_valid,
  input  logic [addr_width-1:0] mem_addr,
  input  logic [data_width-1:0] mem_wdata,
  input  logic [strb_width-1:0] mem_wstrb,
  output logic                  mem_ready,
  output logic [data_width-1:0] mem_rdata,
  output logic                  mem_error,
  output logic                  msip,
  output logic                  mtip,
  output logic                  tx
);

  logic [addr_width-1:0] slave_addr;
  logic                  tim_valid;
  logic                  tim_ready;
  logic [data_width-1:0] tim_rdata;
  logic                  clint_valid;
  logic                  clint_ready;
  logic [data_width-1:0] clint_rdata;
  logic                  uart_valid;
  logic                  uart_ready;
  logic [data_width-1:0] uart_rdata;

  bus_decoder i_bus_decoder (
    .clock      (clock),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .mem_error  (mem_error),
    .slave_addr (slave_addr),
    .tim_valid  (tim_valid),
    .tim_ready  (tim_ready),
    .tim_rdata  (tim_rdata),
    .clint_valid(clint_valid),
    .clint_ready(clint_ready),
    .clint_rdata(clint_rdata),
    .uart_valid (uart_valid),
    .uart_ready (uart_ready),
    .uart_rdata (uart_rdata)
  );

  tim i_tim (
    .clock(clock),
    .reset(reset),
    .valid(tim_valid),
    .addr (slave_addr),
    .wdata(mem_wdata),
    .wstrb(mem_wstrb),
    .ready(tim_ready),
    .rdata(tim_rdata)
  );

  clint i_clint (
    .clock(clock),
    .reset(reset),
    .valid(clint_valid),
    .addr (slave_addr),
    .wdata(mem_wdata),
    .wstrb(mem_wstrb),
    .ready(clint_ready),
    .rdata(clint_rdata),
    .msip (msip),
    .mtip (mtip)
  );

  uart_tx i_uart_tx (
    .clock(clock),
    .reset(reset),
    .valid(uart_valid),
    .addr (slave_addr),
    .wdata(mem_wdata),
    .wstrb(mem_wstrb),
    .ready(uart_ready),
    .rdata(uart_rdata),
    .tx   (tx)
  );

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // period 10.
  end

  initial begin
    reset = 1'b0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;  // released away from the active edge.
  end

endmodule

`default_nettype wire

// ==== tests/tb_soc_bus.sv ====
`default_nettype none

module tb_soc_bus
  import soc_pkg::*;
();

  localparam int frame_cycles = uart_frame_bits * clk_divider_bit;
  localparam int random_accesses = 400;
  localparam int test_cycles = 3 * frame_cycles + 3 * random_accesses + 400;  // worst case.
  localparam int ready_limit = 2 * frame_cycles + 8;

  logic                  clock;
  logic                  reset;
  logic                  mem_valid;
  logic [addr_width-1:0] mem_addr;
  logic [data_width-1:0] mem_wdata;
  logic [strb_width-1:0] mem_wstrb;
  logic                  mem_ready;
  logic [data_width-1:0] mem_rdata;
  logic                  mem_error;
  logic                  msip;
  logic                  mtip;
  logic                  tx;
  logic [data_width-1:0] model [tim_depth];  // expected tim contents.
  logic [strb_width-1:0] known [tim_depth];  // bytes written so far.
  int                    pass_count = 0;
  int                    fail_count = 0;
  int                    test_errors = 0;
  int                    cycle_count = 0;

  clock_gen i_clock_gen (.clock(clock), .reset(reset));

  soc_bus i_dut (
    .clock    (clock),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .mem_error(mem_error),
    .msip     (msip),
    .mtip     (mtip),
    .tx       (tx)
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) pass_count++;
    else begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
      fail_count++;
      test_errors++;
    end
  endtask

  task automatic check_range(input string name, input logic [31:0] low,
                             input logic [31:0] high, input logic [31:0] actual);
    assert (actual >= low && actual <= high) pass_count++;
    else begin
      $display("FAIL %0t %s expected %h to %h actual %h", $time, name, low, high, actual);
      fail_count++;
      test_errors++;
    end
  endtask

  task automatic check_true(input logic condition, input string what);
    assert (condition === 1'b1) pass_count++;
    else begin
      $display("error at %0t: %s", $time, what);
      fail_count++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) $display("%s: passed", name);
    else $display("%s: %0d failed checks", name, test_errors);
    test_errors = 0;
  endtask

  // one request, valid for one cycle, then wait for the ready pulse.
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic error, output int latency);
    @(negedge clock);
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(negedge clock);
    mem_valid = 1'b0;
    latency = 1;
    while (mem_ready !== 1'b1 && latency < ready_limit) begin
      @(negedge clock);
      latency++;
    end
    check_true(mem_ready, $sformatf("no ready from the DUT for address %h", addr));
    rdata = mem_rdata;
    error = mem_error;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, output logic error, output int latency);
    logic [31:0] rdata;
    bus_access(addr, wdata, wstrb, rdata, error, latency);
    check_value("mem_rdata", 32'h0, rdata);  // writes return zero.
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic error, output int latency);
    bus_access(addr, 32'h0, 4'h0, rdata, error, latency);
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] mask;
    for (int i = 0; i < strb_width; i++) mask[8*i+:8] = {8{strb[i]}};
    return mask;
  endfunction

  task automatic expect_ok(input logic error, input int latency);
    check_value("mem_error", 32'h0, 32'(error));
    check_value("ready latency", 32'h1, 32'(latency));
  endtask

  task automatic tim_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    logic error;
    int   latency;
    bus_write(tim_base_addr + 32'(word * 4), data, strb, error, latency);
    expect_ok(error, latency);
    model[word] = (model[word] & ~byte_mask(strb)) | (data & byte_mask(strb));
    known[word] = known[word] | strb;
  endtask

  // only bytes that were written have a defined value.
  task automatic tim_read_check(input int word);
    logic [31:0] rdata;
    logic        error;
    int          latency;
    bus_read(tim_base_addr + 32'(word * 4), rdata, error, latency);
    expect_ok(error, latency);
    check_value("mem_rdata", model[word] & byte_mask(known[word]),
                rdata & byte_mask(known[word]));
  endtask

  // samples tx in the middle of each bit, timed from the start edge.
  task automatic capture_frame(input logic [7:0] data);
    logic [9:0] bits;
    int         waited;
    bits = {1'b1, data, 1'b0};
    waited = 0;
    @(negedge clock);
    while (tx !== 1'b0 && waited < ready_limit) begin
      @(negedge clock);
      waited++;
    end
    check_true(tx === 1'b0, "no start bit on tx");
    for (int i = 0; i < uart_frame_bits; i++) begin
      repeat (i == 0 ? clk_divider_bit / 2 : clk_divider_bit) @(negedge clock);
      check_value("tx", 32'(bits[i]), 32'(tx));
    end
  endtask

  task automatic test_tim_byte_lanes();
    tim_write(16, 32'h1122_3344, 4'hf);
    for (int lane = 0; lane < strb_width; lane++) begin
      tim_write(16, 32'hd4c3_b2a1 + {4{8'(lane)}}, 4'(1 << lane));  // distinct byte per lane.
      tim_read_check(16);
    end
    tim_write(17, 32'hcafe_f00d, 4'hf);
    tim_write(17, 32'h5500_0066, 4'b1001);
    tim_read_check(17);
    report_test("tim byte lanes");
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    logic        error;
    int          latency;
    bus_read(32'h3000_0000, rdata, error, latency);
    check_value("mem_error", 32'h1, 32'(error));
    check_value("mem_rdata", 32'h0, rdata);
    check_value("ready latency", 32'h1, 32'(latency));
    bus_write(32'h0001_1000, 32'hdead_beef, 4'hf, error, latency);
    check_value("mem_error", 32'h1, 32'(error));
    check_value("ready latency", 32'h1, 32'(latency));
    tim_write(3, 32'h0bad_c0de, 4'hf);
    tim_read_check(3);
    report_test("unmapped access");
  endtask

  task automatic test_clint();
    logic [31:0] t1;
    logic [31:0] t2;
    logic        error;
    int          latency;
    int          c1;
    int          waited;
    bus_write(clint_base_addr + clint_msip_offset, 32'h1, 4'hf, error, latency);
    expect_ok(error, latency);
    check_value("msip", 32'h1, 32'(msip));
    bus_write(clint_base_addr + clint_msip_offset, 32'h0, 4'hf, error, latency);
    expect_ok(error, latency);
    check_value("msip", 32'h0, 32'(msip));
    bus_read(clint_base_addr + clint_mtime_offset, t1, error, latency);
    expect_ok(error, latency);
    c1 = cycle_count;
    repeat (50) @(negedge clock);
    bus_read(clint_base_addr + clint_mtime_offset, t2, error, latency);
    expect_ok(error, latency);
    check_range("mtime", t1, t1 + 32'((cycle_count - c1) / clk_divider_rtc) + 32'h1, t2);
    bus_read(clint_base_addr + clint_mtime_offset, t1, error, latency);
    expect_ok(error, latency);
    bus_write(clint_base_addr + clint_mtimecmp_offset + 32'h4, 32'h0, 4'hf, error, latency);
    expect_ok(error, latency);
    bus_write(clint_base_addr + clint_mtimecmp_offset, t1 + 32'h4, 4'hf, error, latency);
    expect_ok(error, latency);
    check_value("mtip", 32'h0, 32'(mtip));
    waited = 0;
    while (mtip !== 1'b1 && waited < 4 * clk_divider_rtc + 2) begin
      @(negedge clock);
      waited++;
    end
    check_true(mtip, "mtip did not rise after mtime reached mtimecmp");
    bus_write(clint_base_addr + clint_mtimecmp_offset + 32'h4, 32'hffff_ffff, 4'hf, error,
              latency);
    expect_ok(error, latency);
    report_test("clint registers and interrupts");
  endtask

  task automatic test_uart_frame();
    logic [7:0]  data;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    data = 8'($urandom());
    fork
      capture_frame(data);
      begin
        bus_write(uart_tx_base_addr + uart_data_offset, {24'h0, data}, 4'hf, error, latency);
        expect_ok(error, latency);
        repeat (40) @(negedge clock);
        bus_read(uart_tx_base_addr + uart_status_offset, rdata, error, latency);
        expect_ok(error, latency);
        check_value("uart busy", 32'h1, rdata);
      end
    join
    repeat (clk_divider_bit) @(negedge clock);  // past the stop bit.
    bus_read(uart_tx_base_addr + uart_status_offset, rdata, error, latency);
    expect_ok(error, latency);
    check_value("uart busy", 32'h0, rdata);
    report_test("uart frame");
  endtask

  task automatic test_uart_backpressure();
    logic [7:0] first;
    logic [7:0] second;
    logic       error;
    int         latency;
    int         c1;
    first = 8'($urandom());
    second = 8'($urandom());
    fork
      begin
        capture_frame(first);
        capture_frame(second);
      end
      begin
        bus_write(uart_tx_base_addr + uart_data_offset, {24'h0, first}, 4'hf, error, latency);
        expect_ok(error, latency);
        c1 = cycle_count;
        bus_write(uart_tx_base_addr + uart_data_offset, {24'h0, second}, 4'hf, error,
                  latency);
        check_value("mem_error", 32'h0, 32'(error));
        check_true(cycle_count - c1 >= frame_cycles, "second write acknowledged mid frame");
      end
    join
    report_test("uart back-pressure");
  endtask

  task automatic test_random_tim();
    int word;
    for (int n = 0; n < random_accesses; n++) begin
      // mostly a small region so reads hit earlier writes.
      word = ($urandom() % 4 == 0) ? int'($urandom() % tim_depth) : int'($urandom() % 32);
      if ($urandom() % 2 == 0) tim_read_check(word);
      else tim_write(word, $urandom(), 4'($urandom() % 15 + 1));
    end
    report_test("random tim traffic");
  endtask

  initial begin
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    for (int i = 0; i < tim_depth; i++) begin
      model[i] = '0;
      known[i] = '0;
    end
    void'($urandom(32'hb0c6));
    wait (reset === 1'b1);
    @(negedge clock);
    test_tim_byte_lanes();
    test_unmapped();
    test_clint();
    test_uart_frame();
    test_uart_backpressure();
    test_random_tim();
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (2 * test_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles, tests did not finish", 2 * test_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_bus.f ====
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/tim.sv
rtl/clint.sv
rtl/uart_tx.sv
rtl/soc_bus.sv
tests/clock_gen.sv
tests/tb_soc_bus.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it, pass or fail comes from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc_bus \
  -f soc_bus.f -o sim_soc_bus

./obj_dir/sim_soc_bus | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
